/* hw/busSizer_params.svh */
`ifndef BUSSIZER_PARAMS_SVH
`define BUSSIZER_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

`define BS_DATA_W 32 // CPU data bus, one long word
`define BS_WORD_W 16 // One half of the long word, the word port width
`define BS_ADDR_W 2  // Low address bits seen by the bridge

////////////////////////////////////////////////////////////
// Address offsets
////////////////////////////////////////////////////////////

// Second word phase of a long word on a word port
`define BS_LOW_WORD_OFS 2'b10

`endif

/* hw/busSizerPkg.sv */
`include "busSizer_params.svh"

package busSizerPkg;

    // CPU transfer size, code 11 is a line transfer and not handled here
    typedef enum logic [1:0] {
        LWORD = 2'b00,
        BYTE  = 2'b01,
        WORD  = 2'b10
    } xferSize_e;

    // Target acknowledge code, the port width comes back with it
    typedef enum logic [1:0] {
        LONG_ACK = 2'b00, // 32-bit port
        WORD_ACK = 2'b01, // 16-bit port
        WAIT_ACK = 2'b11  // Not yet
    } dsackCode_e;

    // Attributes of one CPU cycle
    typedef struct packed {
        logic                  rnw; // High for read
        xferSize_e             siz;
        logic [`BS_ADDR_W-1:0] a;
    } cpuAttr_s;

    typedef struct packed {
        logic [`BS_WORD_W-1:0] hi; // Lanes D31..D16
        logic [`BS_WORD_W-1:0] lo; // Lanes D15..D0
    } wordPair_s;

    // Data bus, seen as one long word or as two words
    typedef union packed {
        logic [`BS_DATA_W-1:0] lw;
        wordPair_s             words;
    } busWord_u;

    // Strobes from the sequencer to the steering unit
    typedef struct packed {
        logic      loadWrite;   // Capture CPU write data
        logic      secondPhase; // Second word phase running
        logic      takeLong;    // Store the whole target long word
        logic      takeHi;      // Target word into the upper half
        logic      takeLo;      // Target word into the lower half
        logic      replicate;   // Target word into both halves
        xferSize_e siz;
        logic      aHi;         // Upper address bit of the cycle
    } steerCtrl_s;

endpackage

/* hw/sizingSequencer.sv */
`include "busSizer_params.svh"

module sizingSequencer
    import busSizerPkg::*;
(
    input  logic                  BCLK,
    input  logic                  nRESET,
    input  logic                  nTsCpu,  // CPU transfer start
    input  cpuAttr_s              cpuAttr,
    input  dsackCode_e            dsack,   // Target acknowledge code
    output logic                  nTs,     // Target transfer start
    output logic                  nTa,     // CPU transfer acknowledge
    output logic                  rnwOut,
    output logic [`BS_ADDR_W-1:0] aOut,
    output steerCtrl_s            steer
);

    ////////////////////////////////////////////////////////////
    // State and cycle attributes
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE        = 2'b00,
        WAIT_FIRST  = 2'b01, // First target phase open
        WAIT_SECOND = 2'b10  // Low word phase of a long word on a word port
    } seqState_e;

    seqState_e state;
    cpuAttr_s  cur;      // Attributes of the cycle in flight

    logic ackSeen;       // Target answered this cycle
    logic needSecond;    // Long word hit a word port
    logic startCycle;    // CPU start accepted

    assign startCycle = (state == IDLE) && !nTsCpu;
    assign ackSeen    = (dsack != WAIT_ACK);

    // Only a long word split over a word port needs a second phase
    assign needSecond = (cur.siz == LWORD) && (dsack == WORD_ACK);

    assign rnwOut = cur.rnw; // Direction holds for the whole cycle

    ////////////////////////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= IDLE;
            nTs   <= 1'b1;
            nTa   <= 1'b1;
            aOut  <= '0;
            cur   <= '{rnw: 1'b1, siz: LWORD, a: '0};
        end else begin
            nTs <= 1'b1; // Both starts and acks are one-cycle pulses
            nTa <= 1'b1;

            case (state)

                IDLE: begin
                    if (startCycle) begin
                        cur   <= cpuAttr;   // Latch attributes
                        aOut  <= cpuAttr.a;
                        nTs   <= 1'b0;      // Start the first phase
                        state <= WAIT_FIRST;
                    end
                end

                WAIT_FIRST: begin
                    if (ackSeen) begin
                        if (needSecond) begin
                            // Upper word done, go fetch or send the lower word
                            nTs   <= 1'b0;
                            aOut  <= `BS_LOW_WORD_OFS;
                            state <= WAIT_SECOND;
                        end else begin
                            nTa   <= 1'b0; // Single phase, finish the CPU cycle
                            state <= IDLE;
                        end
                    end
                end

                WAIT_SECOND: begin
                    if (ackSeen) begin
                        nTa   <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end

            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Steering strobes
    ////////////////////////////////////////////////////////////

    // Strobes act at the same edge as the event they follow
    always_comb begin
        steer             = '0;
        steer.loadWrite   = startCycle && !cpuAttr.rnw; // Write data comes with the start
        steer.secondPhase = (state == WAIT_SECOND);
        steer.siz         = cur.siz;
        steer.aHi         = cur.a[`BS_ADDR_W-1];

        if (cur.rnw && ackSeen) begin
            case (state)
                WAIT_FIRST: begin
                    if (dsack == WORD_ACK) begin
                        if (cur.siz == LWORD) begin
                            steer.takeHi = 1'b1;    // First of two words
                        end else begin
                            steer.replicate = 1'b1; // CPU picks its lanes
                        end
                    end else begin
                        steer.takeLong = 1'b1;      // Long port, whole word
                    end
                end
                WAIT_SECOND: begin
                    steer.takeLo = 1'b1;            // Second word closes the long word
                end
                default: begin
                    steer.takeLong = 1'b0;
                end
            endcase
        end
    end

endmodule

/* hw/dataSteering.sv */
`include "busSizer_params.svh"

module dataSteering
    import busSizerPkg::*;
(
    input  logic       BCLK,
    input  logic       nRESET,
    input  steerCtrl_s steer,      // Strobes from the sequencer
    input  busWord_u   dataCpuIn,  // CPU write data
    input  busWord_u   dataTgtIn,  // Target read data
    output busWord_u   dataTgtOut, // Write lanes toward the target
    output busWord_u   dataCpuOut  // Assembled read word
);

    busWord_u writeReg; // CPU write word of the current cycle
    busWord_u readReg;  // Read assembly register

    logic                  narrowLow; // Byte or word addressed to the lower half
    logic                  lowToHi;   // Lower CPU word goes out on the upper lanes
    logic [`BS_WORD_W-1:0] tgtWord;   // Word port answers on the upper lanes

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    // Loaded with the transfer start
    always_ff @(posedge BCLK) begin
        if (steer.loadWrite) begin
            writeReg <= dataCpuIn;
        end
    end

    assign narrowLow = ((steer.siz == BYTE) || (steer.siz == WORD)) && steer.aHi;
    assign lowToHi   = steer.secondPhase || narrowLow;

    // A word port only looks at D31..D16, so the lower CPU word moves up
    // in the second phase and for narrow cycles at offset 10 or 11
    always_comb begin
        dataTgtOut = writeReg;
        if (lowToHi) begin
            dataTgtOut.words.hi = writeReg.words.lo;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    assign tgtWord = dataTgtIn.words.hi;

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            readReg <= '0;
        end else begin
            if (steer.takeLong) begin
                readReg.lw <= dataTgtIn.lw;         // Long port, all four lanes
            end else if (steer.replicate) begin
                // Same word in both halves, valid for any narrow address
                readReg.words.hi <= tgtWord;
                readReg.words.lo <= tgtWord;
            end else begin
                if (steer.takeHi) begin
                    readReg.words.hi <= tgtWord;    // Offset 00 word
                end
                if (steer.takeLo) begin
                    readReg.words.lo <= tgtWord;    // Offset 10 word
                end
            end
        end
    end

    // Holds until the next read completes
    assign dataCpuOut = readReg;

endmodule

/* hw/busSizerTop.sv */
`include "busSizer_params.svh"

module busSizerTop
    import busSizerPkg::*;
(
    input  logic                  BCLK,
    input  logic                  nRESET,

    // CPU side
    input  logic                  nTsCpu,
    input  cpuAttr_s              cpuAttr,
    input  busWord_u              dataCpuIn,
    output logic                  nTa,
    output busWord_u              dataCpuOut,

    // Target side
    input  dsackCode_e            dsack,
    input  busWord_u              dataTgtIn,
    output logic                  nTs,
    output logic                  rnwOut,
    output logic [`BS_ADDR_W-1:0] aOut,
    output busWord_u              dataTgtOut
);

    ////////////////////////////////////////////////////////////
    // Sequencer and data path
    ////////////////////////////////////////////////////////////

    steerCtrl_s steer; // Sequencer to steering, one way

    sizingSequencer i_sizingSequencer (
        .BCLK    (BCLK),
        .nRESET  (nRESET),
        .nTsCpu  (nTsCpu),
        .cpuAttr (cpuAttr),
        .dsack   (dsack),
        .nTs     (nTs),
        .nTa     (nTa),
        .rnwOut  (rnwOut),
        .aOut    (aOut),
        .steer   (steer)
    );

    dataSteering i_dataSteering (
        .BCLK       (BCLK),
        .nRESET     (nRESET),
        .steer      (steer),
        .dataCpuIn  (dataCpuIn),
        .dataTgtIn  (dataTgtIn),
        .dataTgtOut (dataTgtOut),
        .dataCpuOut (dataCpuOut)
    );

endmodule

/* test/tbBusSizer.sv */
`include "busSizer_params.svh"

module tbBusSizer
    import busSizerPkg::*;
();

    logic                  BCLK;
    logic                  nRESET;
    logic                  nTsCpu;
    cpuAttr_s              cpuAttr;
    busWord_u              dataCpuIn;
    dsackCode_e            dsack;
    busWord_u              dataTgtIn;
    logic                  nTa;
    busWord_u              dataCpuOut;
    logic                  nTs;
    logic                  rnwOut;
    logic [`BS_ADDR_W-1:0] aOut;
    busWord_u              dataTgtOut;

    integer seed = 39;

    // Context of the cycle in flight for stimulus, target and compare
    cpuAttr_s              curAttr;
    dsackCode_e            curPort;    // Port width the target answers with
    busWord_u              curCpu;     // CPU write word
    busWord_u              curTgt;     // Target long word for reads
    int                    phaseCnt;
    logic [`BS_ADDR_W-1:0] recAddr [2];
    busWord_u              recData [2];
    logic                  recRnw;
    int                    cycles   = 0;
    int                    ackCount = 0;

    busSizerTop i_busSizerTop (.*);

    always #2 BCLK = ~BCLK;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic busWord_u expectRead(cpuAttr_s attr, dsackCode_e port,
                                            busWord_u tgtWord);
        busWord_u              res;
        logic [`BS_WORD_W-1:0] w;
        res = tgtWord; // Long port or split long word gives the target word as is
        if (port == WORD_ACK && attr.siz != LWORD) begin
            w            = attr.a[1] ? tgtWord.words.lo : tgtWord.words.hi;
            res.words.hi = w; // Narrow read sees the word in both halves
            res.words.lo = w;
        end
        return res;
    endfunction

    // Phase count and addresses hold for reads as well
    function automatic void expectWrite(input cpuAttr_s attr, input dsackCode_e port,
                                        input busWord_u cpuWord, output int nPh,
                                        output logic [`BS_ADDR_W-1:0] a0,
                                        output logic [`BS_ADDR_W-1:0] a1,
                                        output busWord_u w0, output busWord_u w1);
        busWord_u moved;
        moved.words.hi = cpuWord.words.lo; // Lower word moved onto D31..D16
        moved.words.lo = cpuWord.words.lo;
        nPh = (attr.siz == LWORD && port == WORD_ACK) ? 2 : 1;
        a0  = attr.a;
        a1  = `BS_LOW_WORD_OFS;
        w0  = (attr.siz != LWORD && attr.a[1]) ? moved : cpuWord;
        w1  = moved;
    endfunction

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkWord(string name, busWord_u exp, busWord_u act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp.lw, act.lw);
            abortRun();
        end
    endtask

    task automatic checkAddr(string name, logic [`BS_ADDR_W-1:0] exp,
                             logic [`BS_ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkCount(string name, int exp, int act);
        if (act != exp) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkLevel(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
            abortRun();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Target model
    ////////////////////////////////////////////////////////////

    task automatic servePhase();
        logic [31:0] rnd;
        int          waits;
        rnd   = randWord();
        waits = int'(rnd[1:0]); // 0 to 3 wait cycles
        repeat (waits + 1) begin
            @(posedge BCLK);
            #1;
        end
        if (phaseCnt < 2) begin
            recAddr[phaseCnt] = aOut; // Recorded with the acknowledge
            recData[phaseCnt] = dataTgtOut;
        end
        recRnw = rnwOut;
        phaseCnt++;
        dsack = curPort;
        if (curPort == LONG_ACK) begin
            dataTgtIn = curTgt;
        end else begin
            rnd                = randWord();
            dataTgtIn.words.hi = aOut[1] ? curTgt.words.lo : curTgt.words.hi;
            dataTgtIn.words.lo = rnd[15:0]; // Unused lanes carry junk
        end
        @(posedge BCLK);
        #1;
        dsack = WAIT_ACK;
    endtask

    initial begin
        forever begin
            @(posedge BCLK);
            #1;
            while (nRESET && !nTs) begin // Second phase starts right at the ack
                servePhase();
            end
        end
    end

    // One compare pass per nTa pulse
    always begin
        int                    nPh;
        logic [`BS_ADDR_W-1:0] a0;
        logic [`BS_ADDR_W-1:0] a1;
        busWord_u              w0;
        busWord_u              w1;
        @(posedge BCLK);
        #1;
        if (nRESET && !nTa) begin
            ackCount++;
            expectWrite(curAttr, curPort, curCpu, nPh, a0, a1, w0, w1);
            checkCount("phase count", nPh, phaseCnt);
            checkAddr("aOut phase 0", a0, recAddr[0]);
            checkLevel("rnwOut", curAttr.rnw, recRnw);
            if (nPh == 2) checkAddr("aOut phase 1", a1, recAddr[1]);
            if (curAttr.rnw) begin
                checkWord("dataCpuOut", expectRead(curAttr, curPort, curTgt), dataCpuOut);
            end else begin
                checkWord("dataTgtOut phase 0", w0, recData[0]);
                if (nPh == 2) checkWord("dataTgtOut phase 1", w1, recData[1]);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic runCycle(cpuAttr_s attr, dsackCode_e port, busWord_u cpuWord,
                            busWord_u tgtWord);
        int waitCnt;
        curAttr   = attr;
        curPort   = port;
        curCpu    = cpuWord;
        curTgt    = tgtWord;
        phaseCnt  = 0;
        cycles++;
        cpuAttr   = attr;
        dataCpuIn = cpuWord;
        nTsCpu    = 1'b0;
        @(posedge BCLK);
        #1;
        nTsCpu    = 1'b1;
        cpuAttr   = cpuAttr_s'(randWord()); // Bridge must have latched these
        dataCpuIn = busWord_u'(randWord());
        waitCnt   = 0;
        while (nTa) begin
            @(posedge BCLK);
            #1;
            waitCnt++;
            if (waitCnt > 40) begin
                $display("Timeout: no transfer acknowledge from the bridge at t=%0t", $time);
                abortRun();
            end
        end
        @(posedge BCLK); // Idle gap so the compare can read the context
        #1;
    endtask

    function automatic cpuAttr_s mkAttr(logic rnw, xferSize_e siz, logic [`BS_ADDR_W-1:0] a);
        cpuAttr_s attr;
        attr.rnw = rnw;
        attr.siz = siz;
        attr.a   = a;
        return attr;
    endfunction

    task automatic randomCycle();
        logic [31:0] rnd;
        cpuAttr_s    attr;
        dsackCode_e  port;
        rnd      = randWord();
        attr.rnw = rnd[0];
        attr.siz = (rnd[3:2] == 2'b00) ? LWORD : (rnd[1] ? WORD : BYTE);
        attr.a   = rnd[5:4];
        if (attr.siz == LWORD) attr.a = '0; // Long words are aligned
        if (attr.siz == WORD)  attr.a[0] = 1'b0;
        port     = rnd[8] ? WORD_ACK : LONG_ACK;
        runCycle(attr, port, busWord_u'(randWord()), busWord_u'(randWord()));
    endtask

    initial begin
        BCLK      = 1'b0;
        nRESET    = 1'b0;
        nTsCpu    = 1'b1;
        cpuAttr   = '0;
        dataCpuIn = '0;
        dsack     = WAIT_ACK;
        dataTgtIn = '0;
        phaseCnt  = 0;
        repeat (16) @(posedge BCLK);
        #1;
        nRESET = 1'b1;
        repeat (4) begin   // Idle after reset
            @(posedge BCLK);
            #1;
            checkLevel("nTs", 1'b1, nTs);
            checkLevel("nTa", 1'b1, nTa);
        end

        // Directed reads
        runCycle(mkAttr(1'b1, LWORD, 2'b00), LONG_ACK, '0, busWord_u'(randWord()));
        runCycle(mkAttr(1'b1, LWORD, 2'b00), WORD_ACK, '0, busWord_u'(randWord()));
        runCycle(mkAttr(1'b1, WORD, 2'b00), WORD_ACK, '0, busWord_u'(randWord()));
        runCycle(mkAttr(1'b1, WORD, 2'b10), WORD_ACK, '0, busWord_u'(randWord()));
        runCycle(mkAttr(1'b1, BYTE, 2'b11), WORD_ACK, '0, busWord_u'(randWord()));

        // Directed writes
        runCycle(mkAttr(1'b0, LWORD, 2'b00), LONG_ACK, busWord_u'(randWord()), '0);
        runCycle(mkAttr(1'b0, LWORD, 2'b00), WORD_ACK, busWord_u'(randWord()), '0);
        runCycle(mkAttr(1'b0, WORD, 2'b10), WORD_ACK, busWord_u'(randWord()), '0);
        runCycle(mkAttr(1'b0, BYTE, 2'b01), LONG_ACK, busWord_u'(randWord()), '0);

        repeat (200) randomCycle();

        #1; // After the compare pass of this edge
        if (ackCount == cycles) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("FAIL t=%0t nTa pulses expected %0d actual %0d", $time, cycles, ackCount);
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

/* filelist.f */
+incdir+hw
hw/busSizerPkg.sv
hw/sizingSequencer.sv
hw/dataSteering.sv
hw/busSizerTop.sv
test/tbBusSizer.sv

/* Bender.yml */
package:
  name: busSizer

sources:
  - include_dirs:
      - hw
    files:
      - hw/busSizerPkg.sv
      - hw/sizingSequencer.sv
      - hw/dataSteering.sv
      - hw/busSizerTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tbBusSizer.sv
